// ==== hw/md_pkg.sv ====
package md_pkg;

	localparam int XLEN = 32;
	localparam int MULT_STAGES = 3;
	localparam int DIV_STEPS = 32;

	// divider step counter
	localparam int DIV_CNT_W = $clog2(DIV_STEPS);
	localparam logic [DIV_CNT_W-1:0] DIV_LAST = DIV_CNT_W'(DIV_STEPS - 1);

	// encodings follow the decoder's ALU2Op order for the first four
	typedef enum logic [2:0]
	{
		MD_MULTU = 3'd0,
		MD_MULT  = 3'd1,
		MD_DIVU  = 3'd2,
		MD_DIV   = 3'd3,
		MD_MTHI  = 3'd4,
		MD_MTLO  = 3'd5
	} md_op_e;

	typedef enum logic [1:0]
	{
		IDLE     = 2'd0,
		MUL_WAIT = 2'd1,
		DIV_WAIT = 2'd2,
		DONE     = 2'd3
	} md_state_e;

	// operation as issued by the pipeline
	typedef struct packed
	{
		md_op_e          op;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
	} md_req_t;

	// hi is the upper product word or the remainder
	typedef struct packed
	{
		logic [XLEN-1:0] hi;
		logic [XLEN-1:0] lo;
	} md_result_t;

endpackage

// ==== hw/md_ctrl.sv ====
`timescale 1ns/1ps

module md_ctrl (
	input  logic                     clk,
	input  logic                     aresetn,
	input  logic                     req,
	input  md_pkg::md_req_t          cmd,
	input  logic                     flush,
	input  logic                     mul_valid,
	input  logic                     div_done,
	output logic                     ack,
	output logic                     mul_start,
	output logic                     div_start,
	output logic                     div_abort,
	output logic                     div_signed,
	output logic                     mul_signed,
	output logic                     wr_en_full,
	output logic                     wr_hi,
	output logic                     wr_lo,
	output logic [md_pkg::XLEN-1:0]  wr_word
);

	md_pkg::md_state_e state;
	logic accept;
	logic mul_ok;
	logic div_ok;

	assign accept = (state == md_pkg::IDLE) && req && !flush;
	assign mul_ok = (state == md_pkg::MUL_WAIT) && mul_valid;
	assign div_ok = (state == md_pkg::DIV_WAIT) && div_done;

	// moves commit on the acceptance edge itself
	assign wr_hi = accept && (cmd.op == md_pkg::MD_MTHI);
	assign wr_lo = accept && (cmd.op == md_pkg::MD_MTLO);
	assign wr_word = cmd.a;

	assign wr_en_full = (mul_ok || div_ok) && !flush; // flush drops the result
	assign div_abort = (state == md_pkg::DIV_WAIT) && flush;

	always_ff @(posedge clk)
	begin
		if (!aresetn)
		begin
			state <= md_pkg::IDLE;
			ack <= 1'b0;
			mul_start <= 1'b0;
			div_start <= 1'b0;
			mul_signed <= 1'b0;
			div_signed <= 1'b0;
		end
		else
		begin
			mul_start <= 1'b0; // single cycle pulses
			div_start <= 1'b0;
			case (state)
				md_pkg::IDLE:
					if (req)
					begin
						state <= md_pkg::DONE; // moves and cancelled ops
						if (!flush)
						begin
							case (cmd.op)
								md_pkg::MD_MULT, md_pkg::MD_MULTU:
								begin
									mul_start <= 1'b1;
									mul_signed <= (cmd.op == md_pkg::MD_MULT);
									state <= md_pkg::MUL_WAIT;
								end
								md_pkg::MD_DIV, md_pkg::MD_DIVU:
								begin
									div_start <= 1'b1;
									div_signed <= (cmd.op == md_pkg::MD_DIV);
									state <= md_pkg::DIV_WAIT;
								end
								default: ;
							endcase
						end
					end
				md_pkg::MUL_WAIT, md_pkg::DIV_WAIT:
					if (flush)
						state <= md_pkg::DONE;
					else if (mul_ok || div_ok)
					begin
						state <= md_pkg::DONE;
						ack <= 1'b1; // ack together with the write
					end
				md_pkg::DONE:
					if (req)
						ack <= 1'b1;
					else
					begin
						ack <= 1'b0;
						state <= md_pkg::IDLE;
					end
				default: state <= md_pkg::IDLE;
			endcase
		end
	end

	// four-phase rule seen from the pipeline side
	assert property (@(posedge clk) disable iff (!aresetn) $rose(ack) |-> req)
		else $error("ack rose while req was low");

	// the result mux in md_unit relies on this
	assert property (@(posedge clk) disable iff (!aresetn) !(mul_valid && div_done))
		else $error("multiplier and divider completed together");

endmodule

// ==== hw/md_mult.sv ====
`timescale 1ns/1ps

module md_mult (
	input  logic                     clk,
	input  logic                     aresetn,
	input  logic                     start,
	input  logic                     is_signed,
	input  logic [md_pkg::XLEN-1:0]  a,
	input  logic [md_pkg::XLEN-1:0]  b,
	output logic                     valid,
	output md_pkg::md_result_t       res
);

	logic [md_pkg::MULT_STAGES-1:0] vld; // valid chain, one bit per stage
	logic signed [md_pkg::XLEN:0] a_q;
	logic signed [md_pkg::XLEN:0] b_q;
	logic signed [49:0] pp_lo;
	logic signed [49:0] pp_hi;
	logic signed [65:0] lo_ext;
	logic signed [65:0] hi_ext;
	logic signed [65:0] prod;

	assign lo_ext = pp_lo;
	assign hi_ext = pp_hi;
	assign prod = (hi_ext <<< 16) + lo_ext;

	always_ff @(posedge clk)
	begin
		if (!aresetn)
			vld <= '0;
		else
			vld <= {vld[md_pkg::MULT_STAGES-2:0], start};
	end

	// stage 1 extends to 33 bits so one signed multiply covers both modes
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			a_q <= {is_signed & a[md_pkg::XLEN-1], a};
			b_q <= {is_signed & b[md_pkg::XLEN-1], b};
		end
	end

	// stage 2 splits b at bit 16
	always_ff @(posedge clk)
	begin
		if (vld[0])
		begin
			pp_lo <= a_q * $signed({1'b0, b_q[15:0]}); // low half is unsigned
			pp_hi <= a_q * $signed(b_q[32:16]);
		end
	end

	// stage 3 sums the partial products
	always_ff @(posedge clk)
	begin
		if (vld[1])
			res <= md_pkg::md_result_t'(prod[63:0]);
	end

	assign valid = vld[md_pkg::MULT_STAGES-1];

endmodule

// ==== hw/md_div.sv ====
`timescale 1ns/1ps

module md_div (
	input  logic                     clk,
	input  logic                     aresetn,
	input  logic                     start,
	input  logic                     abort,
	input  logic                     is_signed,
	input  logic [md_pkg::XLEN-1:0]  a,
	input  logic [md_pkg::XLEN-1:0]  b,
	output logic                     done,
	output md_pkg::md_result_t       res
);

	typedef enum logic [1:0]
	{
		DV_IDLE = 2'd0,
		DV_RUN  = 2'd1,
		DV_FIX  = 2'd2
	} div_state_e;

	div_state_e state;
	logic [md_pkg::DIV_CNT_W-1:0] cnt;
	logic [md_pkg::XLEN-1:0] quo; // dividend shifts out, quotient shifts in
	logic [md_pkg::XLEN-1:0] rem;
	logic [md_pkg::XLEN-1:0] dvs;
	logic neg_q;
	logic neg_r;
	logic a_neg;
	logic b_neg;
	logic [md_pkg::XLEN:0] shifted;
	logic [md_pkg::XLEN+1:0] diff;

	assign a_neg = is_signed && a[md_pkg::XLEN-1];
	assign b_neg = is_signed && b[md_pkg::XLEN-1]; // zero divisor counts as positive
	assign shifted = {rem, quo[md_pkg::XLEN-1]};
	assign diff = {1'b0, shifted} - {2'b00, dvs};

	always_ff @(posedge clk)
	begin
		if (!aresetn)
		begin
			state <= DV_IDLE;
			cnt <= '0;
			done <= 1'b0;
		end
		else if (abort)
		begin
			state <= DV_IDLE;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				DV_IDLE:
					if (start)
					begin
						state <= DV_RUN;
						cnt <= '0;
					end
				DV_RUN:
				begin
					cnt <= cnt + 1'b1;
					if (cnt == md_pkg::DIV_LAST)
						state <= DV_FIX;
				end
				DV_FIX:
				begin
					state <= DV_IDLE;
					done <= 1'b1;
				end
				default: state <= DV_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		case (state)
			DV_IDLE:
				if (start)
				begin
					quo <= a_neg ? -a : a;
					rem <= '0;
					dvs <= b_neg ? -b : b;
					neg_q <= a_neg ^ b_neg;
					neg_r <= a_neg; // remainder takes the dividend's sign
				end
			DV_RUN:
			begin
				// restore on borrow, otherwise keep the difference
				quo <= {quo[md_pkg::XLEN-2:0], ~diff[md_pkg::XLEN+1]};
				rem <= diff[md_pkg::XLEN+1] ? shifted[md_pkg::XLEN-1:0]
				                            : diff[md_pkg::XLEN-1:0];
			end
			DV_FIX:
			begin
				res.hi <= neg_r ? -rem : rem;
				res.lo <= neg_q ? -quo : quo;
			end
			default: ;
		endcase
	end

	// one division at a time, enforced by the handshake in md_ctrl
	assert property (@(posedge clk) disable iff (!aresetn) start |-> state == DV_IDLE)
		else $error("divider started while busy");

endmodule

// ==== hw/md_hilo.sv ====
`timescale 1ns/1ps

module md_hilo (
	input  logic                     clk,
	input  logic                     aresetn,
	input  logic                     wr_en_full,
	input  md_pkg::md_result_t       wr_res,
	input  logic                     wr_hi,
	input  logic                     wr_lo,
	input  logic [md_pkg::XLEN-1:0]  wr_word,
	input  logic                     rd_hi,
	output logic [md_pkg::XLEN-1:0]  rd_data
);

	logic [md_pkg::XLEN-1:0] hi;
	logic [md_pkg::XLEN-1:0] lo;

	always_ff @(posedge clk)
	begin
		if (!aresetn)
		begin
			hi <= '0;
			lo <= '0;
		end
		else if (wr_en_full)
		begin
			hi <= wr_res.hi;
			lo <= wr_res.lo;
		end
		else
		begin
			if (wr_hi)
				hi <= wr_word; // MTHI
			if (wr_lo)
				lo <= wr_word; // MTLO
		end
	end

	// read port has no register stage
	assign rd_data = rd_hi ? hi : lo;

	assert property (@(posedge clk) disable iff (!aresetn) !(wr_en_full && (wr_hi || wr_lo)))
		else $error("full and half write in the same cycle");

endmodule

// ==== hw/md_unit.sv ====
`timescale 1ns/1ps

module md_unit (
	input  logic                     clk,
	input  logic                     aresetn,
	input  logic                     req,
	input  md_pkg::md_req_t          cmd,
	input  logic                     flush,
	input  logic                     rd_hi,
	output logic                     ack,
	output logic [md_pkg::XLEN-1:0]  rd_data
);

	logic mul_start;
	logic mul_signed;
	logic mul_valid;
	logic div_start;
	logic div_abort;
	logic div_signed;
	logic div_done;
	logic wr_en_full;
	logic wr_hi;
	logic wr_lo;
	logic [md_pkg::XLEN-1:0] wr_word;
	md_pkg::md_result_t mul_res;
	md_pkg::md_result_t div_res;
	md_pkg::md_result_t wr_res;

	// only one datapath completes per operation
	assign wr_res = mul_valid ? mul_res : div_res;

	md_ctrl u_ctrl (
		.clk        (clk),
		.aresetn    (aresetn),
		.req        (req),
		.cmd        (cmd),
		.flush      (flush),
		.mul_valid  (mul_valid),
		.div_done   (div_done),
		.ack        (ack),
		.mul_start  (mul_start),
		.div_start  (div_start),
		.div_abort  (div_abort),
		.div_signed (div_signed),
		.mul_signed (mul_signed),
		.wr_en_full (wr_en_full),
		.wr_hi      (wr_hi),
		.wr_lo      (wr_lo),
		.wr_word    (wr_word)
	);

	md_mult u_mult (
		.clk       (clk),
		.aresetn   (aresetn),
		.start     (mul_start),
		.is_signed (mul_signed),
		.a         (cmd.a),
		.b         (cmd.b),
		.valid     (mul_valid),
		.res       (mul_res)
	);

	md_div u_div (
		.clk       (clk),
		.aresetn   (aresetn),
		.start     (div_start),
		.abort     (div_abort),
		.is_signed (div_signed),
		.a         (cmd.a),
		.b         (cmd.b),
		.done      (div_done),
		.res       (div_res)
	);

	md_hilo u_hilo (
		.clk        (clk),
		.aresetn    (aresetn),
		.wr_en_full (wr_en_full),
		.wr_res     (wr_res),
		.wr_hi      (wr_hi),
		.wr_lo      (wr_lo),
		.wr_word    (wr_word),
		.rd_hi      (rd_hi),
		.rd_data    (rd_data)
	);

endmodule

// ==== sim/md_unit_checks.svh ====
task automatic check_result(input string name, input md_pkg::md_result_t exp,
	input md_pkg::md_result_t got);
	if (got.hi !== exp.hi)
	begin
		errors++;
		$display("FAIL %s.hi expected %h got %h", name, exp.hi, got.hi);
	end
	if (got.lo !== exp.lo)
	begin
		errors++;
		$display("FAIL %s.lo expected %h got %h", name, exp.lo, got.lo);
	end
endtask

// single word from the read port
task automatic check_word(input string name, input logic [md_pkg::XLEN-1:0] exp,
	input logic [md_pkg::XLEN-1:0] got);
	if (got !== exp)
	begin
		errors++;
		$display("FAIL %s expected %h got %h", name, exp, got);
	end
endtask

// ==== sim/md_unit_tb.sv ====
`timescale 1ns/1ps

module md_unit_tb;

	localparam PATTERN_FILE = "sim/md_patterns.txt";

	// one line of the pattern file
	typedef struct packed
	{
		md_pkg::md_req_t    cmd;
		logic               flush;
		md_pkg::md_result_t exp;
	} pattern_t;

	logic clk;
	logic aresetn;
	logic req;
	md_pkg::md_req_t cmd;
	logic flush;
	logic rd_hi;
	logic ack;
	logic [md_pkg::XLEN-1:0] rd_data;

	pattern_t patterns[$];
	int errors;
	int passed;
	int failed;
	int seed;
	int cycle_count = 0;
	int cycle_limit = 50;

	`include "md_unit_checks.svh"

	md_unit DUT (
		.clk     (clk),
		.aresetn (aresetn),
		.req     (req),
		.cmd     (cmd),
		.flush   (flush),
		.rd_hi   (rd_hi),
		.ack     (ack),
		.rd_data (rd_data)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit)
		begin
			$display("timeout after %0d cycles, a handshake never completed", cycle_count);
			$display("sim failed");
			$finish;
		end
	end

	task automatic load_patterns();
		int fd;
		int n;
		string line;
		logic [31:0] op_v;
		logic [31:0] a_v;
		logic [31:0] b_v;
		logic [31:0] fl_v;
		logic [31:0] hi_v;
		logic [31:0] lo_v;
		pattern_t p;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd != 0)
		begin
			while (!$feof(fd))
			begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.getc(0) != "#") // skip column notes
				begin
					n = $sscanf(line, "%h %h %h %h %h %h", op_v, a_v, b_v, fl_v, hi_v, lo_v);
					if (n == 6)
					begin
						p.cmd.op = md_pkg::md_op_e'(op_v[2:0]);
						p.cmd.a = a_v;
						p.cmd.b = b_v;
						p.flush = fl_v[0];
						p.exp.hi = hi_v;
						p.exp.lo = lo_v;
						patterns.push_back(p);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic apply_reset();
		aresetn <= 1'b0;
		repeat (3) @(posedge clk);
		aresetn <= 1'b1;
	endtask

	// HI then LO through the combinational read port
	task automatic read_hilo(output md_pkg::md_result_t got);
		@(posedge clk);
		rd_hi <= 1'b1;
		@(negedge clk);
		got.hi = rd_data;
		@(posedge clk);
		rd_hi <= 1'b0;
		@(negedge clk);
		got.lo = rd_data;
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before)
		begin
			passed++;
			$display("test %s: pass", name);
		end
		else
		begin
			failed++;
			$display("test %s: fail", name);
		end
	endtask

	task automatic test_reset_state();
		md_pkg::md_result_t got;
		int errors_before;
		errors_before = errors;
		@(negedge clk);
		if (ack !== 1'b0)
		begin
			errors++;
			$display("ack was not low after reset");
		end
		read_hilo(got);
		check_word("rd_data hi", '0, got.hi);
		check_word("rd_data lo", '0, got.lo);
		report_test("reset", errors_before);
	endtask

	task automatic run_test(input int idx);
		pattern_t p;
		md_pkg::md_result_t got;
		int errors_before;
		p = patterns[idx];
		errors_before = errors;
		@(posedge clk);
		req <= 1'b1;
		cmd <= p.cmd;
		@(negedge clk);
		if (ack)
		begin
			errors++;
			$display("ack was high before the request was accepted");
		end
		if (p.flush)
		begin
			repeat (2) @(posedge clk); // exception lands mid operation
			flush <= 1'b1;
			@(posedge clk);
			flush <= 1'b0;
		end
		do
			@(negedge clk);
		while (!ack);
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		if (!ack)
		begin
			errors++;
			$display("ack fell before the unit could see req low");
		end
		while (ack)
			@(negedge clk);
		read_hilo(got);
		if (p.cmd.op == md_pkg::MD_MTHI || p.cmd.op == md_pkg::MD_MTLO)
		begin
			check_word("rd_data hi", p.exp.hi, got.hi);
			check_word("rd_data lo", p.exp.lo, got.lo);
		end
		else
			check_result("hilo", p.exp, got);
		report_test($sformatf("%0d %s flush=%0d", idx + 1, p.cmd.op.name(), p.flush),
			errors_before);
		repeat ($urandom % 4) @(posedge clk); // idle gap
	endtask

	initial
	begin
		aresetn = 1'b0;
		req = 1'b0;
		cmd = '0;
		flush = 1'b0;
		rd_hi = 1'b0;
		errors = 0;
		passed = 0;
		failed = 0;
		seed = 55847;
		void'($urandom(seed));
		load_patterns();
		cycle_limit = patterns.size() * (md_pkg::DIV_STEPS + 3 + 3 + 4) + 50;
		apply_reset();
		test_reset_state();
		if (patterns.size() == 0)
		begin
			failed++;
			$display("no test patterns could be read from %s", PATTERN_FILE);
		end
		else
		begin
			foreach (patterns[i])
				run_test(i);
		end
		$display("tests passed %0d, tests failed %0d", passed, failed);
		if (failed == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== md_unit.f ====
+incdir+sim
hw/md_pkg.sv
hw/md_ctrl.sv
hw/md_mult.sv
hw/md_div.sv
hw/md_hilo.sv
hw/md_unit.sv
sim/md_unit_tb.sv

// ==== sim/md_patterns.txt ====
# columns: op a b flush exp_hi exp_lo (hex)
# op codes: 0 MULTU  1 MULT  2 DIVU  3 DIV  4 MTHI  5 MTLO
4 deadbeef 00000000 0 deadbeef 00000000
5 12345678 00000000 0 deadbeef 12345678
0 00000007 00000006 0 00000000 0000002a
1 fffffffd 00000005 0 ffffffff fffffff1
0 ffffffff ffffffff 0 fffffffe 00000001
1 ffffffff ffffffff 0 00000000 00000001
1 80000000 80000000 0 40000000 00000000
0 00010000 00010000 0 00000001 00000000
1 ffff0000 00010000 0 ffffffff 00000000
1 7fffffff 00000002 0 00000000 fffffffe
2 00000064 00000007 0 00000002 0000000e
3 ffffff9c 00000007 0 fffffffe fffffff2
3 00000064 fffffff9 0 00000002 fffffff2
3 ffffff9c fffffff9 0 fffffffe 0000000e
2 ffffffff 00000010 0 0000000f 0fffffff
2 12345678 00000000 0 12345678 ffffffff
3 fffffff9 00000000 0 fffffff9 00000001
3 80000000 ffffffff 0 00000000 80000000
1 00000002 00000003 1 00000000 80000000
2 0000000a 00000003 1 00000000 80000000
5 cafef00d 00000000 0 00000000 cafef00d
3 00000064 00000007 1 00000000 cafef00d
